// File: fetch_unit.f
+incdir+src
src/ifu_pkg.sv
src/fetch_if.sv
src/pc_gen.sv
src/if1_fifo_reg.sv
src/fetch_buffer.sv
src/inst_issue.sv
src/fetch_unit.sv
test/fetch_unit_tb.sv

// File: Bender.yml
package:
  name: fetch_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ifu_pkg.sv
      - src/fetch_if.sv
      - src/pc_gen.sv
      - src/if1_fifo_reg.sv
      - src/fetch_buffer.sv
      - src/inst_issue.sv
      - src/fetch_unit.sv

  - target: test
    include_dirs:
      - src
    files:
      - test/fetch_unit_tb.sv

// File: test/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module fetch_unit_tb;

    localparam int          NUM_CASES    = 8;
    localparam int          STALL_LIMIT  = 200;
    localparam int          QUIET_CYCLES = 40;
    localparam logic [31:0] NO_ERR_ADDR  = 32'hffff_fff8;

    typedef struct {
        string       name;
        bit          from_reset;
        logic [31:0] target;
        int          count;
        logic [31:0] err_addr;
        int          ready_pct;
        bit          busy_redirect;
    } case_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic        excp;
        logic [6:0]  ecode;
    } entry_t;

    logic        clk;
    logic        rstn;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_rvalid;
    logic [31:0] imem_rdata0;
    logic [31:0] imem_rdata1;
    logic        imem_err;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst_pc;
    logic [31:0] inst_word;
    logic        inst_excp_flag;
    logic [6:0]  inst_ecode;

    case_t       cases [NUM_CASES];
    entry_t      exp_q [$];
    logic [31:0] mem_words [logic [29:0]];
    logic [31:0] err_addr;

    fetch_unit dut_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_rvalid    (imem_rvalid),
        .imem_rdata0    (imem_rdata0),
        .imem_rdata1    (imem_rdata1),
        .imem_err       (imem_err),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_excp_flag (inst_excp_flag),
        .inst_ecode     (inst_ecode)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;
        end
    end

    task automatic fail_run(input string what);
        $display("test failed");
        $display("ERROR: %s", what);
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("test failed");
            $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // words appear on first touch, so memory and model always agree.
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [29:0] key;
        key = addr[31:2];
        if (!mem_words.exists(key)) begin
            mem_words[key] = $urandom;
        end
        return mem_words[key];
    endfunction

    task automatic build_expected(input logic [31:0] target, input int count,
                                  input logic [31:0] bad_addr);
        logic [31:0] addr;
        entry_t      e;
        logic        halted;
        exp_q.delete();
        halted = 1'b0;
        addr   = target;
        if (target[1:0] != 2'b00) begin
            e = '{pc: target, word: `IFU_INST_NOP, excp: 1'b1, ecode: `IFU_ECODE_ADEF};
            exp_q.push_back(e);
            halted = 1'b1;
        end
        while (!halted && exp_q.size() < count) begin
            if (addr[31:3] == bad_addr[31:3]) begin
                e = '{pc: {addr[31:3], 3'b000}, word: `IFU_INST_NOP, excp: 1'b1,
                      ecode: `IFU_ECODE_IFE};
                halted = 1'b1;
            end else begin
                e = '{pc: addr, word: word_at(addr), excp: 1'b0, ecode: 7'h00};
            end
            exp_q.push_back(e);
            addr = addr + 32'd4;
        end
    endtask

    // one request at a time, answered 1 to 3 cycles after acceptance.
    initial begin : memory_model
        logic        busy;
        int          delay;
        logic [31:0] req_addr;
        busy        = 1'b0;
        delay       = 0;
        req_addr    = 32'h0;
        imem_rvalid = 1'b0;
        imem_rdata0 = 32'h0;
        imem_rdata1 = 32'h0;
        imem_err    = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            imem_rvalid = 1'b0;
            if (!rstn) begin
                busy = 1'b0;
            end else if (busy) begin
                if (delay == 0) begin
                    imem_rvalid = 1'b1;
                    imem_rdata0 = word_at(req_addr);
                    imem_rdata1 = word_at(req_addr + 32'd4);
                    imem_err    = req_addr[31:3] == err_addr[31:3];
                    busy        = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
            @(negedge clk);
            if (rstn && imem_req) begin
                if (busy) begin
                    fail_run("memory request issued while another was outstanding");
                end
                busy     = 1'b1;
                req_addr = imem_addr;
                delay    = $urandom_range(2, 0);
            end
        end
    end

    task automatic apply_reset();
        int cycles;
        rstn       = 1'b0;
        redirect   = 1'b0;
        inst_ready = 1'b0;
        for (cycles = 0; cycles < 10; cycles++) begin
            @(negedge clk);
            compare("reset imem_req", 32'd0, imem_req);
            compare("reset inst_valid", 32'd0, inst_valid);
            @(posedge clk);
            #2;
        end
        rstn       = 1'b1;
        inst_ready = 1'b1;
        cycles     = 0;
        @(negedge clk);
        while (!imem_req) begin
            cycles++;
            if (cycles > 5) begin
                fail_run("no memory request after reset release");
            end
            @(negedge clk);
        end
        compare("reset first imem_addr", `IFU_PC_RESET, imem_addr);
        @(posedge clk);
        #2;
    endtask

    // let packets pile up, then return just after a request was accepted.
    task automatic stall_until_request();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            inst_ready = cycles >= 6;
            @(negedge clk);
            seen = imem_req && cycles >= 2;
            cycles++;
            if (cycles > STALL_LIMIT) begin
                fail_run("no memory request seen before redirect");
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic apply_redirect(input logic [31:0] target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #2;
        redirect = 1'b0;
    endtask

    task automatic collect_entries(input string name, input int ready_pct);
        int     idx;
        int     idle_cycles;
        entry_t e;
        idx         = 0;
        idle_cycles = 0;
        while (idx < exp_q.size()) begin
            inst_ready = $urandom_range(99, 0) < ready_pct;
            @(negedge clk);
            if (inst_valid && inst_ready) begin
                e = exp_q[idx];
                compare($sformatf("%s entry %0d pc", name, idx), e.pc, inst_pc);
                compare($sformatf("%s entry %0d word", name, idx), e.word, inst_word);
                compare($sformatf("%s entry %0d excp", name, idx), e.excp, inst_excp_flag);
                compare($sformatf("%s entry %0d ecode", name, idx), e.ecode, inst_ecode);
                idx++;
                idle_cycles = 0;
            end else begin
                idle_cycles++;
                if (idle_cycles > STALL_LIMIT) begin
                    fail_run($sformatf("%s: timeout waiting for entry %0d", name, idx));
                end
            end
            @(posedge clk);
            #2;
        end
    endtask

    // after a fault nothing may issue and no request may go out.
    task automatic check_quiet(input string name);
        int cycles;
        inst_ready = 1'b1;
        for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
            @(negedge clk);
            compare({name, " trailing inst_valid"}, 32'd0, inst_valid);
            compare({name, " trailing imem_req"}, 32'd0, imem_req);
            @(posedge clk);
            #2;
        end
    endtask

    initial begin : stimulus
        int    k;
        case_t c;
        rstn        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = 32'h0;
        inst_ready  = 1'b0;
        err_addr    = NO_ERR_ADDR;
        void'($urandom(32'h1ef0_8501));

        // name, from reset, target, count, error address, ready %, redirect in flight.
        cases[0] = '{"reset_stream", 1'b1, `IFU_PC_RESET, 24, NO_ERR_ADDR, 100, 1'b0};
        cases[1] = '{"upper_target", 1'b0, 32'h1c00_1004, 12, NO_ERR_ADDR, 100, 1'b1};
        cases[2] = '{"misaligned_target", 1'b0, 32'h1c00_2002, 4, NO_ERR_ADDR, 100, 1'b1};
        cases[3] = '{"mem_error", 1'b0, 32'h1c00_3000, 16, 32'h1c00_3014, 100, 1'b0};
        cases[4] = '{"random_ready", 1'b0, 32'h1c00_4008, 40, NO_ERR_ADDR, 40, 1'b0};
        cases[5] = '{"redirect_in_flight", 1'b0, 32'h1c00_5000, 16, NO_ERR_ADDR, 70, 1'b1};
        cases[6] = '{"misaligned_busy", 1'b0, 32'h1c00_6001, 4, NO_ERR_ADDR, 50, 1'b1};
        cases[7] = '{"error_random_ready", 1'b0, 32'h1c00_7004, 30, 32'h1c00_7024, 30, 1'b0};

        for (k = 0; k < NUM_CASES; k++) begin
            c        = cases[k];
            err_addr = c.err_addr;
            build_expected(c.target, c.count, c.err_addr);
            if (c.from_reset) begin
                apply_reset();
            end else begin
                if (c.busy_redirect) begin
                    stall_until_request();
                end
                apply_redirect(c.target);
            end
            collect_entries(c.name, c.ready_pct);
            if (exp_q[exp_q.size() - 1].excp) begin
                check_quiet(c.name);
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic        clk,
    input  logic        rstn,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_rvalid,
    input  logic [31:0] imem_rdata0,
    input  logic [31:0] imem_rdata1,
    input  logic        imem_err,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst_pc,
    output logic [31:0] inst_word,
    output logic        inst_excp_flag,
    output logic [6:0]  inst_ecode
);

    fetch_if if1_bus ();
    fetch_if reg_bus ();
    fetch_if buf_bus ();

    pc_gen pc_gen_i (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rvalid (imem_rvalid),
        .imem_rdata0 (imem_rdata0),
        .imem_rdata1 (imem_rdata1),
        .imem_err    (imem_err),
        .out         (if1_bus.source)
    );

    if1_fifo_reg if1_fifo_reg_i (
        .clk      (clk),
        .rstn     (rstn),
        .redirect (redirect),
        .in       (if1_bus.sink),
        .out      (reg_bus.source)
    );

    fetch_buffer fetch_buffer_i (
        .clk      (clk),
        .rstn     (rstn),
        .redirect (redirect),
        .in       (reg_bus.sink),
        .out      (buf_bus.source)
    );

    inst_issue inst_issue_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect       (redirect),
        .in             (buf_bus.sink),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_excp_flag (inst_excp_flag),
        .inst_ecode     (inst_ecode)
    );

endmodule

`default_nettype wire

// File: src/inst_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module inst_issue import ifu_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        redirect,
    fetch_if.sink       in,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst_pc,
    output logic [31:0] inst_word,
    output logic        inst_excp_flag,
    output logic [6:0]  inst_ecode
);

    logic       slot_q;
    logic       cur_slot;
    logic       last_slot;
    logic       excp;
    fetch_pkt_t head;

    assign head = in.pkt;
    assign excp = head.excp_flag;

    // slot 0 is passed over once issued or when the mask leaves it empty.
    assign cur_slot  = slot_q || !head.slot_valid[0];
    assign last_slot = excp || cur_slot || !head.slot_valid[1];

    // the head packet leaves with its final instruction.
    assign in.ready = inst_ready && last_slot;

    assign inst_valid     = in.valid && !redirect;
    assign inst_pc        = excp ? head.badv : head.pc + {29'd0, cur_slot, 2'b00};
    assign inst_word      = excp ? `IFU_INST_NOP : (cur_slot ? head.inst1 : head.inst0);
    assign inst_excp_flag = excp;
    assign inst_ecode     = head.ecode;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_q <= 1'b0;
        end else if (redirect) begin
            slot_q <= 1'b0;
        end else if (inst_valid && inst_ready) begin
            slot_q <= !last_slot;
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module fetch_buffer import ifu_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    redirect,
    fetch_if.sink   in,
    fetch_if.source out
);

    localparam int DEPTH = `IFU_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkt_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] nxt;
        // wraps back to entry 0 after the last entry.
        nxt = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
        return nxt;
    endfunction

    assign in.ready  = count != CNT_W'(DEPTH);
    assign out.valid = count != '0;
    assign out.pkt   = mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.pkt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/if1_fifo_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module if1_fifo_reg import ifu_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    redirect,
    fetch_if.sink   in,
    fetch_if.source out
);

    localparam fetch_pkt_t EMPTY_PKT = '{
        pc:         32'h0,
        slot_valid: 2'b00,
        inst0:      `IFU_INST_NOP,
        inst1:      `IFU_INST_NOP,
        badv:       32'h0,
        ecode:      7'h00,
        excp_flag:  1'b0
    };

    logic       valid_q;
    fetch_pkt_t pkt_q;
    logic       load;
    logic       drain;

    // take a new packet when empty or when the current one leaves now.
    assign in.ready = !valid_q || out.ready;
    assign load     = in.valid && in.ready;
    assign drain    = !in.valid && out.ready;

    assign out.valid = valid_q;
    assign out.pkt   = pkt_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (redirect) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    // stalled output keeps the entry as it is.
    always_ff @(posedge clk) begin
        if (redirect || drain) begin
            pkt_q <= EMPTY_PKT;
        end else if (load) begin
            pkt_q <= in.pkt;
        end
    end

endmodule

`default_nettype wire

// File: src/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module pc_gen import ifu_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_rvalid,
    input  logic [31:0] imem_rdata0,
    input  logic [31:0] imem_rdata1,
    input  logic        imem_err,
    fetch_if.source     out
);

    logic        run;
    logic [31:0] pc;
    logic        waiting;
    logic        drop;
    logic        halted;
    logic        pkt_valid;
    fetch_pkt_t  pkt;
    logic [31:0] pc_pair;
    logic        misaligned;
    logic        idle;
    logic        adef_start;
    logic        rsp_take;

    assign pc_pair    = {pc[31:3], 3'b000};
    assign misaligned = pc[1:0] != 2'b00;
    // free to act with nothing in flight and no packet waiting downstream.
    assign idle       = run && !waiting && !pkt_valid && !halted && !redirect;
    assign adef_start = idle && misaligned;
    assign rsp_take   = imem_rvalid && waiting && !drop && !redirect;

    assign imem_req  = idle && !misaligned;
    assign imem_addr = pc_pair;

    assign out.valid = pkt_valid;
    assign out.pkt   = pkt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run       <= 1'b0;
            pc        <= `IFU_PC_RESET;
            waiting   <= 1'b0;
            drop      <= 1'b0;
            halted    <= 1'b0;
            pkt_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (redirect) begin
                pc        <= redirect_pc;
                halted    <= 1'b0;
                pkt_valid <= 1'b0;
                // a response still owed by memory belongs to the old path.
                waiting   <= waiting && !imem_rvalid;
                drop      <= waiting && !imem_rvalid;
            end else begin
                if (out.valid && out.ready) begin
                    pkt_valid <= 1'b0;
                end
                if (imem_req) begin
                    waiting <= 1'b1;
                end
                if (adef_start) begin
                    pkt_valid <= 1'b1;
                    halted    <= 1'b1;
                end
                if (imem_rvalid && waiting) begin
                    waiting <= 1'b0;
                    drop    <= 1'b0;
                end
                if (rsp_take) begin
                    pkt_valid <= 1'b1;
                    if (imem_err) begin
                        halted <= 1'b1;
                    end else begin
                        pc <= pc_pair + 32'd8;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adef_start) begin
            pkt.pc         <= pc_pair;
            pkt.slot_valid <= 2'b01;
            pkt.inst0      <= 32'h0;
            pkt.inst1      <= 32'h0;
            pkt.badv       <= pc;
            pkt.ecode      <= `IFU_ECODE_ADEF;
            pkt.excp_flag  <= 1'b1;
        end else if (rsp_take) begin
            pkt.pc         <= pc_pair;
            // a target in the upper word skips slot 0.
            pkt.slot_valid <= (imem_err || !pc[2]) ? {!imem_err, 1'b1} : 2'b10;
            pkt.inst0      <= imem_rdata0;
            pkt.inst1      <= imem_rdata1;
            pkt.badv       <= imem_err ? pc_pair : 32'h0;
            pkt.ecode      <= imem_err ? `IFU_ECODE_IFE : 7'h00;
            pkt.excp_flag  <= imem_err;
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import ifu_pkg::*; ();

    logic       valid;
    logic       ready;
    fetch_pkt_t pkt;

    modport source (
        output valid,
        output pkt,
        input  ready
    );

    modport sink (
        input  valid,
        input  pkt,
        output ready
    );

endinterface

`default_nettype wire

// File: src/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

    // bit 0 marks inst0 valid, bit 1 marks inst1 valid.
    typedef logic [1:0] slot_mask_t;

    // one memory access worth of instructions, or one fault.
    typedef struct packed {
        logic [31:0] pc;
        slot_mask_t  slot_valid;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] badv;
        logic [6:0]  ecode;
        logic        excp_flag;
    } fetch_pkt_t;

endpackage

`default_nettype wire

// File: src/ifu_settings.svh
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// first fetch address after reset.
`define IFU_PC_RESET 32'h1c00_0000

// andi r0, r0, 0.
`define IFU_INST_NOP 32'h0340_0000

// packets held in the fetch buffer, 2, 4 or 8.
`define IFU_BUF_DEPTH 4

// exception codes carried in fetch packets.
`define IFU_ECODE_ADEF 7'h08
`define IFU_ECODE_IFE  7'h0f

`endif
